/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_ex_stage
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
logic/riscv_isa_pkg.sv
logic/ex_pkg.sv
logic/ex_decode.sv
logic/alu.sv
logic/branch_unit.sv
logic/lsu.sv
logic/ex_stage.sv
sim/tb_ex_stage.sv

/* logic/alu.sv */
`default_nettype none

module alu (
    input  wire ex_pkg::alu_op_e        op,
    input  wire logic [ex_pkg::XLEN-1:0] a,
    input  wire logic [ex_pkg::XLEN-1:0] b,
    output logic [ex_pkg::XLEN-1:0]      y
);
    import ex_pkg::*;

    logic [SHAMT_W-1:0] shamt;

    assign shamt = b[SHAMT_W-1:0];

    always_comb begin
        case (op)
            ADD: begin
                y = a + b;
            end
            SUB: begin
                y = a - b;
            end
            SLL: begin
                y = a << shamt;
            end
            SLT: begin
                y = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            end
            SLTU: begin
                y = {{(XLEN-1){1'b0}}, a < b};
            end
            XOR: begin
                y = a ^ b;
            end
            SRL: begin
                y = a >> shamt;
            end
            SRA: begin
                // sign fill
                y = $signed(a) >>> shamt;
            end
            OR: begin
                y = a | b;
            end
            AND: begin
                y = a & b;
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/branch_unit.sv */
`default_nettype none

module branch_unit (
    input  wire ex_pkg::br_cond_e        cond,
    input  wire logic                    is_jalr,
    input  wire logic [ex_pkg::XLEN-1:0] pc,
    input  wire logic [ex_pkg::XLEN-1:0] rs1,
    input  wire logic [ex_pkg::XLEN-1:0] rs2,
    input  wire logic [ex_pkg::XLEN-1:0] imm,
    output logic                         jump_flag,
    output logic [ex_pkg::XLEN-1:0]      jump_addr
);
    import ex_pkg::*;

    logic            taken;
    logic [XLEN-1:0] target;

    always_comb begin
        case (cond)
            EQ:      taken = (rs1 == rs2);
            NE:      taken = (rs1 != rs2);
            LT:      taken = ($signed(rs1) < $signed(rs2));
            GE:      taken = ($signed(rs1) >= $signed(rs2));
            LTU:     taken = (rs1 < rs2);
            GEU:     taken = (rs1 >= rs2);
            ALWAYS:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // jalr target has bit 0 cleared
    assign target = is_jalr ? ((rs1 + imm) & ~XLEN'(1)) : (pc + imm);

    assign jump_flag = taken;
    assign jump_addr = taken ? target : '0;

endmodule

`default_nettype wire

/* logic/ex_decode.sv */
`default_nettype none

module ex_decode (
    input  wire logic [ex_pkg::XLEN-1:0] inst,
    output ex_pkg::alu_op_e              alu_op,
    output logic                         use_imm,
    output ex_pkg::br_cond_e             br_cond,
    output logic                         is_jalr,
    output ex_pkg::mem_size_e            mem_size,
    output logic                         load_unsigned,
    output logic                         is_store,
    output logic                         is_load,
    output ex_pkg::res_sel_e             res_sel
);
    import ex_pkg::*;
    import riscv_isa_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt;

    // SUB only exists in R-type, SRA in both
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt_bit,
                                         input logic r_type);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = (alt_bit && r_type) ? SUB : ADD;
            F3_SLL:     op = SLL;
            F3_SLT:     op = SLT;
            F3_SLTU:    op = SLTU;
            F3_XOR:     op = XOR;
            F3_SRL_SRA: op = alt_bit ? SRA : SRL;
            F3_OR:      op = OR;
            F3_AND:     op = AND;
            default:    op = NONE;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(inst[OPC_MSB:OPC_LSB]);
    assign funct3 = inst[F3_MSB:F3_LSB];
    assign alt    = inst[ALT_BIT];

    always_comb begin
        alu_op        = NONE;
        use_imm       = 1'b0;
        br_cond       = NEVER;
        is_jalr       = 1'b0;
        mem_size      = BAD;
        load_unsigned = 1'b0;
        is_store      = 1'b0;
        is_load       = 1'b0;
        res_sel       = ALU;

        case (opcode)
            OP_R: begin
                alu_op = arith_op(funct3, alt, 1'b1);
            end
            OP_I: begin
                alu_op  = arith_op(funct3, alt, 1'b0);
                use_imm = 1'b1;
            end
            OP_B: begin
                case (funct3)
                    F3_BEQ:  br_cond = EQ;
                    F3_BNE:  br_cond = NE;
                    F3_BLT:  br_cond = LT;
                    F3_BGE:  br_cond = GE;
                    F3_BLTU: br_cond = LTU;
                    F3_BGEU: br_cond = GEU;
                    default: br_cond = NEVER;
                endcase
            end
            OP_S: begin
                is_store = 1'b1;
                case (funct3)
                    F3_B:    mem_size = BYTE;
                    F3_H:    mem_size = HALF;
                    F3_W:    mem_size = WORD;
                    default: mem_size = BAD;
                endcase
            end
            OP_L: begin
                is_load = 1'b1;
                res_sel = LOAD;
                case (funct3)
                    F3_B:    mem_size = BYTE;
                    F3_H:    mem_size = HALF;
                    F3_W:    mem_size = WORD;
                    F3_BU:   mem_size = BYTE;
                    F3_HU:   mem_size = HALF;
                    default: mem_size = BAD;
                endcase
                load_unsigned = (funct3 == F3_BU) || (funct3 == F3_HU);
            end
            OP_LUI:   res_sel = IMM;
            OP_AUIPC: res_sel = PC_IMM;
            OP_JAL: begin
                br_cond = ALWAYS;
                res_sel = PC_4;
            end
            OP_JALR: begin
                br_cond = ALWAYS;
                is_jalr = 1'b1;
                res_sel = PC_4;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* logic/ex_pkg.sv */
`default_nettype none

package ex_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    // bytes per data word
    localparam int LANES      = 4;
    localparam int SHAMT_W    = 5;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        NONE
    } alu_op_e;

    typedef enum logic [2:0] {
        EQ,
        NE,
        LT,
        GE,
        LTU,
        GEU,
        ALWAYS,
        NEVER
    } br_cond_e;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD,
        BAD
    } mem_size_e;

    // source of the writeback data
    typedef enum logic [2:0] {
        ALU,
        IMM,
        PC_IMM,
        PC_4,
        LOAD
    } res_sel_e;

endpackage

`default_nettype wire

/* logic/ex_stage.sv */
`default_nettype none

module ex_stage (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic [ex_pkg::XLEN-1:0]       pc,
    input  wire logic [ex_pkg::XLEN-1:0]       inst,
    input  wire logic [ex_pkg::XLEN-1:0]       reg1,
    input  wire logic [ex_pkg::XLEN-1:0]       reg2,
    input  wire logic [ex_pkg::XLEN-1:0]       imm,
    input  wire logic [ex_pkg::REG_ADDR_W-1:0] reg_waddr,
    input  wire logic                          reg_we,
    input  wire logic [ex_pkg::XLEN-1:0]       ram_rdata,
    output logic                               ram_we,
    output logic [ex_pkg::LANES-1:0]           ram_sel,
    output logic [ex_pkg::XLEN-1:0]            ram_addr,
    output logic [ex_pkg::XLEN-1:0]            ram_wdata,
    output logic                               jump_flag,
    output logic [ex_pkg::XLEN-1:0]            jump_addr,
    output logic [ex_pkg::REG_ADDR_W-1:0]      waddr,
    output logic [ex_pkg::XLEN-1:0]            wdata,
    output logic                               we
);
    import ex_pkg::*;

    alu_op_e         alu_op;
    logic            use_imm;
    br_cond_e        br_cond;
    logic            is_jalr;
    mem_size_e       mem_size;
    logic            load_unsigned;
    logic            is_store;
    logic            is_load;
    res_sel_e        res_sel;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_y;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] result;

    ex_decode u_decode (
        .inst          (inst),
        .alu_op        (alu_op),
        .use_imm       (use_imm),
        .br_cond       (br_cond),
        .is_jalr       (is_jalr),
        .mem_size      (mem_size),
        .load_unsigned (load_unsigned),
        .is_store      (is_store),
        .is_load       (is_load),
        .res_sel       (res_sel)
    );

    assign alu_b = use_imm ? imm : reg2;

    alu u_alu (
        .op (alu_op),
        .a  (reg1),
        .b  (alu_b),
        .y  (alu_y)
    );

    branch_unit u_branch (
        .cond      (br_cond),
        .is_jalr   (is_jalr),
        .pc        (pc),
        .rs1       (reg1),
        .rs2       (reg2),
        .imm       (imm),
        .jump_flag (jump_flag),
        .jump_addr (jump_addr)
    );

    lsu u_lsu (
        .size          (mem_size),
        .load_unsigned (load_unsigned),
        .is_store      (is_store),
        .is_load       (is_load),
        .base          (reg1),
        .offset        (imm),
        .store_data    (reg2),
        .ram_rdata     (ram_rdata),
        .ram_we        (ram_we),
        .ram_sel       (ram_sel),
        .ram_addr      (ram_addr),
        .ram_wdata     (ram_wdata),
        .load_data     (load_data)
    );

    always_comb begin
        case (res_sel)
            ALU:     result = alu_y;
            IMM:     result = imm;
            PC_IMM:  result = pc + imm;
            PC_4:    result = pc + XLEN'(4);
            LOAD:    result = load_data;
            default: result = '0;
        endcase
    end

    // stage register towards memory / writeback
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we    <= 1'b0;
            waddr <= '0;
            wdata <= '0;
        end else begin
            we    <= reg_we;
            waddr <= reg_waddr;
            wdata <= result;
        end
    end

    a_we_reset: assert property (@(posedge clk) !rst_n |-> !we && waddr == '0 && wdata == '0);

    a_jump_addr_zero: assert property (@(posedge clk) !jump_flag |-> jump_addr == '0);

    // decode and lsu must agree that a load never writes
    a_load_no_write: assert property (@(posedge clk) is_load |-> !ram_we && ram_sel == '0);

endmodule

`default_nettype wire

/* logic/lsu.sv */
`default_nettype none

module lsu (
    input  wire ex_pkg::mem_size_e       size,
    input  wire logic                    load_unsigned,
    input  wire logic                    is_store,
    input  wire logic                    is_load,
    input  wire logic [ex_pkg::XLEN-1:0] base,
    input  wire logic [ex_pkg::XLEN-1:0] offset,
    input  wire logic [ex_pkg::XLEN-1:0] store_data,
    input  wire logic [ex_pkg::XLEN-1:0] ram_rdata,
    output logic                         ram_we,
    output logic [ex_pkg::LANES-1:0]     ram_sel,
    output logic [ex_pkg::XLEN-1:0]      ram_addr,
    output logic [ex_pkg::XLEN-1:0]      ram_wdata,
    output logic [ex_pkg::XLEN-1:0]      load_data
);
    import ex_pkg::*;

    logic [XLEN-1:0]          addr;
    logic [$clog2(LANES)-1:0] lane;
    logic                     access;
    logic [7:0]               ld_byte;
    logic [15:0]              ld_half;

    assign addr   = base + offset;
    assign lane   = addr[$clog2(LANES)-1:0];
    assign access = (is_store || is_load) && (size != BAD);

    assign ram_addr = access ? addr : '0;
    assign ram_we   = is_store && (size != BAD);

    // store lanes and replicated data
    always_comb begin
        ram_sel   = '0;
        ram_wdata = '0;
        if (is_store) begin
            case (size)
                BYTE: begin
                    ram_sel   = LANES'(1) << lane;
                    ram_wdata = {LANES{store_data[7:0]}};
                end
                HALF: begin
                    // misaligned half enables nothing
                    if (lane == 2'd0) begin
                        ram_sel = 4'b0011;
                    end else if (lane == 2'd2) begin
                        ram_sel = 4'b1100;
                    end
                    ram_wdata = {2{store_data[15:0]}};
                end
                WORD: begin
                    ram_sel   = '1;
                    ram_wdata = store_data;
                end
                default: ;
            endcase
        end
    end

    assign ld_byte = ram_rdata[8*lane +: 8];
    assign ld_half = ram_rdata[16*lane[1] +: 16];

    always_comb begin
        load_data = '0;
        if (is_load) begin
            case (size)
                BYTE: begin
                    load_data = {{(XLEN-8){ld_byte[7] & ~load_unsigned}}, ld_byte};
                end
                HALF: begin
                    if (!lane[0]) begin
                        load_data = {{(XLEN-16){ld_half[15] & ~load_unsigned}}, ld_half};
                    end
                end
                WORD: begin
                    load_data = ram_rdata;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/riscv_isa_pkg.sv */
`default_nettype none

package riscv_isa_pkg;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP_R     = 7'b0110011,
        OP_I     = 7'b0010011,
        OP_S     = 7'b0100011,
        OP_L     = 7'b0000011,
        OP_B     = 7'b1100011,
        OP_LUI   = 7'b0110111,
        OP_AUIPC = 7'b0010111,
        OP_JAL   = 7'b1101111,
        OP_JALR  = 7'b1100111
    } opcode_e;

    // instruction field positions
    localparam int OPC_LSB = 0;
    localparam int OPC_MSB = 6;
    localparam int F3_LSB  = 12;
    localparam int F3_MSB  = 14;
    // selects SUB and SRA
    localparam int ALT_BIT = 30;

    // arithmetic funct3, same for OP_R and OP_I
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // load / store size
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

endpackage

`default_nettype wire

/* sim/tb_ex_stage.sv */
`default_nettype none

module tb_ex_stage;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [6:0] OPC_R     = 7'h33;
    localparam logic [6:0] OPC_I     = 7'h13;
    localparam logic [6:0] OPC_S     = 7'h23;
    localparam logic [6:0] OPC_L     = 7'h03;
    localparam logic [6:0] OPC_B     = 7'h63;
    localparam logic [6:0] OPC_LUI   = 7'h37;
    localparam logic [6:0] OPC_AUIPC = 7'h17;
    localparam logic [6:0] OPC_JAL   = 7'h6f;
    localparam logic [6:0] OPC_JALR  = 7'h67;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] reg1;
        logic [31:0] reg2;
        logic [31:0] imm;
        logic [31:0] rdata;
        logic [4:0]  waddr;
        logic [31:0] exp_wdata;
        logic        exp_jf;
        logic [31:0] exp_ja;
        logic        exp_rwe;
        logic [3:0]  exp_sel;
        logic [31:0] exp_addr;
        logic [31:0] exp_rwdata;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] reg1;
    logic [31:0] reg2;
    logic [31:0] imm;
    logic [4:0]  reg_waddr;
    logic        reg_we;
    logic [31:0] ram_rdata;
    logic        ram_we;
    logic [3:0]  ram_sel;
    logic [31:0] ram_addr;
    logic [31:0] ram_wdata;
    logic        jump_flag;
    logic [31:0] jump_addr;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        we;

    row_t        rows[$];
    logic [31:0] lcg_state;

    ex_stage UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .pc        (pc),
        .inst      (inst),
        .reg1      (reg1),
        .reg2      (reg2),
        .imm       (imm),
        .reg_waddr (reg_waddr),
        .reg_we    (reg_we),
        .ram_rdata (ram_rdata),
        .ram_we    (ram_we),
        .ram_sel   (ram_sel),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .jump_flag (jump_flag),
        .jump_addr (jump_addr),
        .waddr     (waddr),
        .wdata     (wdata),
        .we        (we)
    );

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

    // only opcode, funct3 and bit 30 matter to the stage
    function automatic logic [31:0] encode(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic alt);
        return {1'b0, alt, 15'd0, f3, 5'd0, opc};
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // reference arithmetic per the RV32I rules
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic r_type, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] fill;
        sh = b[4:0];
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
        case (f3)
            3'd0:    return (r_type && alt) ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? ((a >> sh) | fill) : (a >> sh);
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic add_row(input logic [31:0] p, input logic [31:0] i, input logic [31:0] r1,
                           input logic [31:0] r2, input logic [31:0] im,
                           input logic [31:0] rd, input logic [4:0] wa,
                           input logic [31:0] wd, input logic jf, input logic [31:0] ja,
                           input logic rwe, input logic [3:0] sel, input logic [31:0] ad,
                           input logic [31:0] rwd);
        row_t r;
        r = '{p, i, r1, r2, im, rd, wa, wd, jf, ja, rwe, sel, ad, rwd};
        rows.push_back(r);
    endtask

    task automatic apply_inputs(input logic [31:0] p, input logic [31:0] i,
                                input logic [31:0] r1, input logic [31:0] r2,
                                input logic [31:0] im, input logic [31:0] rd,
                                input logic [4:0] wa);
        pc        = p;
        inst      = i;
        reg1      = r1;
        reg2      = r2;
        imm       = im;
        ram_rdata = rd;
        reg_waddr = wa;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s expected %h got %h", name, expected, actual);
            $display("Something failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    initial begin
        row_t        r;
        logic [31:0] rnd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] im;
        logic [31:0] expected;
        logic [2:0]  f3;
        logic        alt;
        logic        r_type;
        int          cycles;

        lcg_state  = 32'd44865;
        reg_we     = 1'b0;
        apply_inputs(0, 0, 0, 0, 0, 0, 5'd0);

        // arithmetic, register and immediate forms
        add_row(0, encode(OPC_R, 3'd0, 1'b0), 5, 7, 0, 0, 5'd1, 12, 1'b0, 0, 1'b0, 4'h0, 0, 0);
        add_row(0, encode(OPC_R, 3'd0, 1'b1), 5, 7, 0, 0, 5'd2, 'hffff_fffe,
                1'b0, 0, 1'b0, 4'h0, 0, 0);
        add_row(0, encode(OPC_R, 3'd5, 1'b1), 'h8000_0010, 'h24, 0, 0, 5'd3, 'hf800_0001,
                1'b0, 0, 1'b0, 4'h0, 0, 0);
        add_row(0, encode(OPC_R, 3'd5, 1'b0), 'h8000_0010, 'h24, 0, 0, 5'd4, 'h0800_0001,
                1'b0, 0, 1'b0, 4'h0, 0, 0);
        add_row(0, encode(OPC_R, 3'd2, 1'b0), 'hffff_ffff, 1, 0, 0, 5'd5, 1,
                1'b0, 0, 1'b0, 4'h0, 0, 0);
        add_row(0, encode(OPC_R, 3'd3, 1'b0), 'hffff_ffff, 1, 0, 0, 5'd6, 0,
                1'b0, 0, 1'b0, 4'h0, 0, 0);
        add_row(0, encode(OPC_R, 3'd1, 1'b0), 1, 'h21, 0, 0, 5'd7, 2, 1'b0, 0, 1'b0, 4'h0, 0, 0);
        add_row(0, encode(OPC_R, 3'd6, 1'b0), 'hf0, 'h0f, 0, 0, 5'd8, 'hff,
                1'b0, 0, 1'b0, 4'h0, 0, 0);
        add_row(0, encode(OPC_I, 3'd4, 1'b0), 'hf0f0_f0f0, 'h1234_5678, 'hffff_ffff, 0, 5'd9,
                'h0f0f_0f0f, 1'b0, 0, 1'b0, 4'h0, 0, 0);
        // bit 30 set on an immediate add is still an add
        add_row(0, encode(OPC_I, 3'd0, 1'b1), 10, 99, 'h400, 0, 5'd10, 'h40a,
                1'b0, 0, 1'b0, 4'h0, 0, 0);
        add_row(0, encode(OPC_I, 3'd5, 1'b1), 'hffff_ff00, 0, 'h404, 0, 5'd11, 'hffff_fff0,
                1'b0, 0, 1'b0, 4'h0, 0, 0);
        add_row(0, encode(OPC_I, 3'd7, 1'b0), 'h1234_5678, 0, 'hff, 0, 5'd12, 'h78,
                1'b0, 0, 1'b0, 4'h0, 0, 0);
        add_row(0, encode(OPC_I, 3'd2, 1'b0), 5, 0, 'hffff_ffff, 0, 5'd13, 0,
                1'b0, 0, 1'b0, 4'h0, 0, 0);
        add_row(0, encode(OPC_I, 3'd3, 1'b0), 5, 0, 'hffff_ffff, 0, 5'd14, 1,
                1'b0, 0, 1'b0, 4'h0, 0, 0);

        // branches, taken then not taken
        add_row('h100, encode(OPC_B, 3'd0, 1'b0), 'h55, 'h55, 'h20, 0, 5'd0, 0,
                1'b1, 'h120, 1'b0, 4'h0, 0, 0);
        add_row('h100, encode(OPC_B, 3'd0, 1'b0), 'h55, 'h56, 'h20, 0, 5'd0, 0,
                1'b0, 0, 1'b0, 4'h0, 0, 0);
        add_row('h100, encode(OPC_B, 3'd1, 1'b0), 'h55, 'h56, 'h20, 0, 5'd0, 0,
                1'b1, 'h120, 1'b0, 4'h0, 0, 0);
        add_row('h100, encode(OPC_B, 3'd1, 1'b0), 'h55, 'h55, 'h20, 0, 5'd0, 0,
                1'b0, 0, 1'b0, 4'h0, 0, 0);
        add_row('h100, encode(OPC_B, 3'd4, 1'b0), 'h8000_0000, 'h7fff_ffff, 'h20, 0, 5'd0, 0,
                1'b1, 'h120, 1'b0, 4'h0, 0, 0);
        add_row('h100, encode(OPC_B, 3'd4, 1'b0), 'h7fff_ffff, 'h8000_0000, 'h20, 0, 5'd0, 0,
                1'b0, 0, 1'b0, 4'h0, 0, 0);
        add_row('h100, encode(OPC_B, 3'd5, 1'b0), 'h7fff_ffff, 'h8000_0000, 'h20, 0, 5'd0, 0,
                1'b1, 'h120, 1'b0, 4'h0, 0, 0);
        add_row('h100, encode(OPC_B, 3'd5, 1'b0), 'h8000_0000, 'h7fff_ffff, 'h20, 0, 5'd0, 0,
                1'b0, 0, 1'b0, 4'h0, 0, 0);
        add_row('h100, encode(OPC_B, 3'd6, 1'b0), 'h7fff_ffff, 'h8000_0000, 'h20, 0, 5'd0, 0,
                1'b1, 'h120, 1'b0, 4'h0, 0, 0);
        add_row('h100, encode(OPC_B, 3'd6, 1'b0), 'h8000_0000, 'h7fff_ffff, 'h20, 0, 5'd0, 0,
                1'b0, 0, 1'b0, 4'h0, 0, 0);
        add_row('h100, encode(OPC_B, 3'd7, 1'b0), 'h8000_0000, 'h7fff_ffff, 'h20, 0, 5'd0, 0,
                1'b1, 'h120, 1'b0, 4'h0, 0, 0);
        add_row('h100, encode(OPC_B, 3'd7, 1'b0), 'h7fff_ffff, 'h8000_0000, 'h20, 0, 5'd0, 0,
                1'b0, 0, 1'b0, 4'h0, 0, 0);
        add_row('h200, encode(OPC_JAL, 3'd0, 1'b0), 0, 0, 'h40, 0, 5'd1, 'h204,
                1'b1, 'h240, 1'b0, 4'h0, 0, 0);
        add_row('h200, encode(OPC_JALR, 3'd0, 1'b0), 'h1001, 0, 'h10, 0, 5'd1, 'h204,
                1'b1, 'h1010, 1'b0, 4'h0, 0, 0);

        // stores
        add_row(0, encode(OPC_S, 3'd0, 1'b0), 'h1000, 'haabb_ccdd, 0, 0, 5'd0, 0,
                1'b0, 0, 1'b1, 4'h1, 'h1000, 'hdddd_dddd);
        add_row(0, encode(OPC_S, 3'd0, 1'b0), 'h1000, 'haabb_ccdd, 1, 0, 5'd0, 0,
                1'b0, 0, 1'b1, 4'h2, 'h1001, 'hdddd_dddd);
        add_row(0, encode(OPC_S, 3'd0, 1'b0), 'h1000, 'haabb_ccdd, 2, 0, 5'd0, 0,
                1'b0, 0, 1'b1, 4'h4, 'h1002, 'hdddd_dddd);
        add_row(0, encode(OPC_S, 3'd0, 1'b0), 'h1000, 'haabb_ccdd, 3, 0, 5'd0, 0,
                1'b0, 0, 1'b1, 4'h8, 'h1003, 'hdddd_dddd);
        add_row(0, encode(OPC_S, 3'd1, 1'b0), 'h1000, 'haabb_ccdd, 0, 0, 5'd0, 0,
                1'b0, 0, 1'b1, 4'h3, 'h1000, 'hccdd_ccdd);
        add_row(0, encode(OPC_S, 3'd1, 1'b0), 'h1000, 'haabb_ccdd, 2, 0, 5'd0, 0,
                1'b0, 0, 1'b1, 4'hc, 'h1002, 'hccdd_ccdd);
        // misaligned half, no lanes
        add_row(0, encode(OPC_S, 3'd1, 1'b0), 'h1000, 'haabb_ccdd, 1, 0, 5'd0, 0,
                1'b0, 0, 1'b1, 4'h0, 'h1001, 'hccdd_ccdd);
        add_row(0, encode(OPC_S, 3'd2, 1'b0), 'h2000, 'haabb_ccdd, 8, 0, 5'd0, 0,
                1'b0, 0, 1'b1, 4'hf, 'h2008, 'haabb_ccdd);
        add_row(0, encode(OPC_S, 3'd3, 1'b0), 'h2000, 'haabb_ccdd, 8, 0, 5'd0, 0,
                1'b0, 0, 1'b0, 4'h0, 0, 0);

        // loads from bytes 22 7f f1 80, then lui and auipc
        add_row(0, encode(OPC_L, 3'd0, 1'b0), 'h1000, 'h5555_5555, 2, 'h80f1_7f22, 5'd20,
                'hffff_fff1, 1'b0, 0, 1'b0, 4'h0, 'h1002, 0);
        add_row(0, encode(OPC_L, 3'd4, 1'b0), 'h1000, 'h5555_5555, 2, 'h80f1_7f22, 5'd21,
                'hf1, 1'b0, 0, 1'b0, 4'h0, 'h1002, 0);
        add_row(0, encode(OPC_L, 3'd0, 1'b0), 'h1000, 'h5555_5555, 1, 'h80f1_7f22, 5'd22,
                'h7f, 1'b0, 0, 1'b0, 4'h0, 'h1001, 0);
        add_row(0, encode(OPC_L, 3'd0, 1'b0), 'h1000, 'h5555_5555, 3, 'h80f1_7f22, 5'd23,
                'hffff_ff80, 1'b0, 0, 1'b0, 4'h0, 'h1003, 0);
        add_row(0, encode(OPC_L, 3'd1, 1'b0), 'h1000, 'h5555_5555, 2, 'h80f1_7f22, 5'd24,
                'hffff_80f1, 1'b0, 0, 1'b0, 4'h0, 'h1002, 0);
        add_row(0, encode(OPC_L, 3'd5, 1'b0), 'h1000, 'h5555_5555, 2, 'h80f1_7f22, 5'd25,
                'h80f1, 1'b0, 0, 1'b0, 4'h0, 'h1002, 0);
        add_row(0, encode(OPC_L, 3'd1, 1'b0), 'h1000, 'h5555_5555, 0, 'h80f1_7f22, 5'd26,
                'h7f22, 1'b0, 0, 1'b0, 4'h0, 'h1000, 0);
        add_row(0, encode(OPC_L, 3'd1, 1'b0), 'h1000, 'h5555_5555, 1, 'h80f1_7f22, 5'd27,
                0, 1'b0, 0, 1'b0, 4'h0, 'h1001, 0);
        add_row(0, encode(OPC_L, 3'd2, 1'b0), 'h1000, 'h5555_5555, 0, 'h80f1_7f22, 5'd28,
                'h80f1_7f22, 1'b0, 0, 1'b0, 4'h0, 'h1000, 0);
        add_row(0, encode(OPC_LUI, 3'd0, 1'b0), 0, 0, 'h1234_5000, 0, 5'd29, 'h1234_5000,
                1'b0, 0, 1'b0, 4'h0, 0, 0);
        add_row('h400, encode(OPC_AUIPC, 3'd0, 1'b0), 0, 0, 'h1234_5000, 0, 5'd30,
                'h1234_5400, 1'b0, 0, 1'b0, 4'h0, 0, 0);

        // register outputs stay cleared through reset
        cycles = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            #1;
            check_value("we", 32'd0, 32'(we));
            check_value("waddr", 32'd0, 32'(waddr));
            check_value("wdata", 32'd0, wdata);
            cycles++;
            if (cycles > 20) begin
                $display("reset was never released");
                $display("Something failed");
                $fatal(1, "reset release timeout");
            end
        end

        reg_we = 1'b1;
        for (int k = 0; k < rows.size(); k++) begin
            r = rows[k];
            #1;
            apply_inputs(r.pc, r.inst, r.reg1, r.reg2, r.imm, r.rdata, r.waddr);
            #36;
            check_value("jump_flag", 32'(r.exp_jf), 32'(jump_flag));
            check_value("jump_addr", r.exp_ja, jump_addr);
            check_value("ram_we", 32'(r.exp_rwe), 32'(ram_we));
            check_value("ram_sel", 32'(r.exp_sel), 32'(ram_sel));
            check_value("ram_addr", r.exp_addr, ram_addr);
            check_value("ram_wdata", r.exp_rwdata, ram_wdata);
            @(posedge clk);
            #1;
            check_value("we", 32'd1, 32'(we));
            check_value("waddr", 32'(r.waddr), 32'(waddr));
            check_value("wdata", r.exp_wdata, wdata);
        end

        // random register and immediate operations
        for (int n = 0; n < 200; n++) begin
            rnd = lcg_next();
            f3 = rnd[2:0];
            alt = rnd[3];
            r_type = rnd[4];
            a = lcg_next();
            b = lcg_next();
            im = lcg_next();
            expected = alu_model(f3, alt, r_type, a, r_type ? b : im);
            #1;
            apply_inputs(0, encode(r_type ? OPC_R : OPC_I, f3, alt), a, b, im, 0, rnd[12:8]);
            #36;
            check_value("jump_flag", 32'd0, 32'(jump_flag));
            check_value("ram_we", 32'd0, 32'(ram_we));
            @(posedge clk);
            #1;
            check_value("waddr", 32'(rnd[12:8]), 32'(waddr));
            check_value("wdata", expected, wdata);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire
